/* Makefile */
TOP = lcd_ctrl_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f flist.f

sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -f flist.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* design/frame_buffer.sv */
`default_nettype none

module frame_buffer (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   load_en,
    input  lcd_pkg::addr_t        rom_addr,
    input  lcd_pkg::pixel_t       rom_q,
    input  lcd_pkg::addr_t [3:0]  win_addr_all,
    input  wire                   win_we,
    input  lcd_pkg::pixel_t       win_value,
    input  wire                   out_en,
    input  lcd_pkg::addr_t        out_addr,
    output lcd_pkg::pixel_t [3:0] win_pix,
    output logic                  ram_valid,
    output lcd_pkg::pixel_t       ram_data,
    output lcd_pkg::addr_t        ram_addr
);
    import lcd_pkg::*;

    pixel_t mem [IMG_PIXELS];

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[rom_addr] <= rom_q;
        end else if (win_we) begin
            for (int i = 0; i < 4; i++) begin
                mem[win_addr_all[i]] <= win_value;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            win_pix[i] = mem[win_addr_all[i]];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ram_valid <= 1'b0;
        end else begin
            ram_valid <= out_en;
        end
    end

    always_ff @(posedge clk) begin
        if (out_en) begin
            ram_addr <= out_addr;
            // first window beat bypasses the write landing on the same edge
            if (win_we) begin
                ram_data <= win_value;
            end else begin
                ram_data <= mem[out_addr];
            end
        end
    end

endmodule

`default_nettype wire

/* design/lcd_ctrl.sv */
`default_nettype none

module lcd_ctrl (
    input  wire             clk,
    input  wire             reset,
    input  wire  [3:0]      cmd,
    input  wire             cmd_valid,
    input  lcd_pkg::pixel_t rom_q,
    output logic            rom_rd,
    output lcd_pkg::addr_t  rom_addr,
    output logic            ram_valid,
    output lcd_pkg::pixel_t ram_data,
    output lcd_pkg::addr_t  ram_addr,
    output logic            busy,
    output logic            done
);
    import lcd_pkg::*;

    logic         last;
    logic         cnt_clear;
    logic         cnt_step;
    count_mode_t  cnt_mode;
    cmd_t         op;
    logic         shift_en;
    logic         win_we;
    logic         out_en;
    logic         out_sel_window;
    addr_t        count;
    addr_t        win_addr;
    addr_t        out_addr;
    addr_t [3:0]  win_addr_all;
    pixel_t [3:0] win_pix;
    pixel_t       win_value;

    assign rom_addr = count;
    assign out_addr = out_sel_window ? win_addr : count;   // window beat or raster beat

    lcd_ctrl_fsm u_fsm (
        .clk            (clk),
        .reset          (reset),
        .cmd            (cmd),
        .cmd_valid      (cmd_valid),
        .last           (last),
        .busy           (busy),
        .done           (done),
        .rom_rd         (rom_rd),
        .cnt_clear      (cnt_clear),
        .cnt_step       (cnt_step),
        .cnt_mode       (cnt_mode),
        .op             (op),
        .shift_en       (shift_en),
        .win_we         (win_we),
        .out_en         (out_en),
        .out_sel_window (out_sel_window)
    );

    lcd_step_counter u_counter (
        .clk   (clk),
        .reset (reset),
        .clear (cnt_clear),
        .step  (cnt_step),
        .mode  (cnt_mode),
        .count (count),
        .last  (last)
    );

    op_point u_point (
        .clk          (clk),
        .reset        (reset),
        .shift_en     (shift_en),
        .shift_cmd    (op),
        .win_sel      (count[1:0]),
        .win_addr     (win_addr),
        .win_addr_all (win_addr_all)
    );

    window_alu u_alu (
        .win_pix (win_pix),
        .op      (op),
        .result  (win_value)
    );

    frame_buffer u_buffer (
        .clk          (clk),
        .reset        (reset),
        .load_en      (rom_rd),
        .rom_addr     (count),
        .rom_q        (rom_q),
        .win_addr_all (win_addr_all),
        .win_we       (win_we),
        .win_value    (win_value),
        .out_en       (out_en),
        .out_addr     (out_addr),
        .win_pix      (win_pix),
        .ram_valid    (ram_valid),
        .ram_data     (ram_data),
        .ram_addr     (ram_addr)
    );

endmodule

`default_nettype wire

/* design/lcd_ctrl_fsm.sv */
`default_nettype none

module lcd_ctrl_fsm (
    input  wire                  clk,
    input  wire                  reset,
    input  wire  [3:0]           cmd,
    input  wire                  cmd_valid,
    input  wire                  last,
    output logic                 busy,
    output logic                 done,
    output logic                 rom_rd,
    output logic                 cnt_clear,
    output logic                 cnt_step,
    output lcd_pkg::count_mode_t cnt_mode,
    output lcd_pkg::cmd_t        op,
    output logic                 shift_en,
    output logic                 win_we,
    output logic                 out_en,
    output logic                 out_sel_window
);
    import lcd_pkg::*;

    state_t state, state_next;
    logic   accept;
    logic   win_first;   // first beat of a window op
    logic   write_end;   // last write beat just went out

    assign accept = cmd_valid && !busy;

    always_comb begin
        state_next = state;
        case (state)
            S_LOAD: if (last) state_next = S_IDLE;
            S_IDLE: begin
                if (accept) begin
                    case (cmd)
                        CMD_WRITE:                               state_next = S_WRITE;
                        CMD_MAX, CMD_MIN, CMD_AVG:               state_next = S_WINDOW;
                        default:                                 state_next = S_SHIFT;
                    endcase
                end
            end
            S_WRITE:  if (last) state_next = S_IDLE;
            S_WINDOW: if (last) state_next = S_IDLE;
            S_SHIFT:  state_next = S_IDLE;   // shifts and unused codes
            default:  state_next = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= S_LOAD;
            busy      <= 1'b1;
            done      <= 1'b0;
            op        <= CMD_WRITE;
            win_first <= 1'b0;
            write_end <= 1'b0;
        end else begin
            state <= state_next;
            if (state == S_IDLE) begin
                if (accept) begin
                    busy <= 1'b1;
                    op   <= cmd_t'(cmd);
                end else begin
                    busy <= 1'b0;
                end
            end
            win_first <= (state_next == S_WINDOW) && (state != S_WINDOW);
            write_end <= (state == S_WRITE) && last;
            if (write_end) done <= 1'b1;   // sticky until reset
        end
    end

    always_comb begin
        rom_rd         = (state == S_LOAD);
        cnt_step       = (state == S_LOAD) || (state == S_WRITE) || (state == S_WINDOW);
        cnt_clear      = cnt_step && last;
        cnt_mode       = (state == S_WINDOW) ? CNT_WINDOW : CNT_IMAGE;
        shift_en       = (state == S_SHIFT);
        out_en         = (state == S_WRITE) || (state == S_WINDOW);
        out_sel_window = (state == S_WINDOW);
        win_we         = (state == S_WINDOW) && win_first;
    end

endmodule

`default_nettype wire

/* design/lcd_pkg.sv */
`default_nettype none

package lcd_pkg;

    typedef logic [7:0] pixel_t;
    typedef logic [5:0] addr_t;   // row * 8 + col
    typedef logic [2:0] coord_t;
    typedef logic [9:0] sum_t;    // four pixels summed

    localparam int IMG_SIDE   = 8;
    localparam int IMG_PIXELS = 64;
    localparam int WIN_PIXELS = 4;

    // operation point range, both axes
    localparam int POS_MIN   = 1;
    localparam int POS_MAX   = 7;
    localparam int POS_RESET = 4;

    // codes 8 to 15 are accepted as no operation
    typedef enum logic [3:0] {
        CMD_WRITE = 4'd0,
        CMD_UP    = 4'd1,
        CMD_DOWN  = 4'd2,
        CMD_LEFT  = 4'd3,
        CMD_RIGHT = 4'd4,
        CMD_MAX   = 4'd5,
        CMD_MIN   = 4'd6,
        CMD_AVG   = 4'd7
    } cmd_t;

    typedef enum logic [2:0] {
        S_LOAD,
        S_IDLE,
        S_WRITE,
        S_SHIFT,
        S_WINDOW
    } state_t;

    typedef enum logic [1:0] {
        CNT_IMAGE,   // 64 beats
        CNT_WINDOW   // 4 beats
    } count_mode_t;

endpackage

`default_nettype wire

/* design/lcd_step_counter.sv */
`default_nettype none

module lcd_step_counter (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  clear,
    input  wire                  step,
    input  lcd_pkg::count_mode_t mode,
    output lcd_pkg::addr_t       count,
    output logic                 last
);
    import lcd_pkg::*;

    // one counter serves load, write-out and window phases
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (step) begin
            count <= count + 6'd1;
        end
    end

    always_comb begin
        if (mode == CNT_WINDOW) begin
            last = (count == addr_t'(WIN_PIXELS - 1));
        end else begin
            last = (count == addr_t'(IMG_PIXELS - 1));
        end
    end

endmodule

`default_nettype wire

/* design/op_point.sv */
`default_nettype none

module op_point (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 shift_en,
    input  lcd_pkg::cmd_t       shift_cmd,
    input  wire  [1:0]          win_sel,
    output lcd_pkg::addr_t      win_addr,
    output lcd_pkg::addr_t [3:0] win_addr_all
);
    import lcd_pkg::*;

    coord_t pos_x;
    coord_t pos_y;
    coord_t row0;   // top row of the window
    coord_t col0;   // left column of the window
    addr_t  p0;

    always_ff @(posedge clk) begin
        if (reset) begin
            pos_x <= coord_t'(POS_RESET);
            pos_y <= coord_t'(POS_RESET);
        end else if (shift_en) begin
            case (shift_cmd)
                CMD_UP:    if (pos_y > coord_t'(POS_MIN)) pos_y <= pos_y - 3'd1;
                CMD_DOWN:  if (pos_y < coord_t'(POS_MAX)) pos_y <= pos_y + 3'd1;
                CMD_LEFT:  if (pos_x > coord_t'(POS_MIN)) pos_x <= pos_x - 3'd1;
                CMD_RIGHT: if (pos_x < coord_t'(POS_MAX)) pos_x <= pos_x + 3'd1;
                default: begin
                    // no move for other opcodes
                end
            endcase
        end
    end

    assign row0 = pos_y - 3'd1;
    assign col0 = pos_x - 3'd1;
    assign p0   = addr_t'(row0 * IMG_SIDE + col0);

    // upper left, upper right, lower left, lower right
    assign win_addr_all[0] = p0;
    assign win_addr_all[1] = p0 + 6'd1;
    assign win_addr_all[2] = p0 + addr_t'(IMG_SIDE);
    assign win_addr_all[3] = p0 + addr_t'(IMG_SIDE + 1);

    assign win_addr = win_addr_all[win_sel];   // address of the current beat

endmodule

`default_nettype wire

/* design/window_alu.sv */
`default_nettype none

module window_alu (
    input  lcd_pkg::pixel_t [3:0] win_pix,
    input  lcd_pkg::cmd_t         op,
    output lcd_pkg::pixel_t       result
);
    import lcd_pkg::*;

    pixel_t max_top, max_bot, max_all;
    pixel_t min_top, min_bot, min_all;
    sum_t   sum;

    // first level compares within each row, second across rows
    assign max_top = (win_pix[0] > win_pix[1]) ? win_pix[0] : win_pix[1];
    assign max_bot = (win_pix[2] > win_pix[3]) ? win_pix[2] : win_pix[3];
    assign max_all = (max_top > max_bot) ? max_top : max_bot;

    assign min_top = (win_pix[0] < win_pix[1]) ? win_pix[0] : win_pix[1];
    assign min_bot = (win_pix[2] < win_pix[3]) ? win_pix[2] : win_pix[3];
    assign min_all = (min_top < min_bot) ? min_top : min_bot;

    assign sum = sum_t'(win_pix[0]) + sum_t'(win_pix[1]) + sum_t'(win_pix[2])
               + sum_t'(win_pix[3]);

    always_comb begin
        case (op)
            CMD_MAX: result = max_all;
            CMD_MIN: result = min_all;
            default: result = sum[9:2];   // truncated average
        endcase
    end

endmodule

`default_nettype wire

/* flist.f */
design/lcd_pkg.sv
design/lcd_step_counter.sv
design/op_point.sv
design/window_alu.sv
design/frame_buffer.sv
design/lcd_ctrl_fsm.sv
design/lcd_ctrl.sv
verif/lcd_ctrl_tb.sv

/* verif/lcd_ctrl_tb.sv */
`default_nettype none

module lcd_ctrl_tb;
    import lcd_pkg::*;

    localparam int CLK_HALF       = 20;
    localparam int RESET_CYCLES   = 8;
    localparam int CYCLES_PER_CMD = 200;
    localparam int STIM_WORDS     = 512;
    localparam int SPUR_BASE      = IMG_PIXELS;   // count word, then the codes
    localparam logic [7:0] END_MARK = 8'hff;

    logic       clk = 1'b0;
    logic       reset;
    logic [3:0] cmd;
    logic       cmd_valid;
    pixel_t     rom_q;
    logic       rom_rd;
    addr_t      rom_addr;
    logic       ram_valid;
    pixel_t     ram_data;
    addr_t      ram_addr;
    logic       busy;
    logic       done;

    logic [7:0] stim [STIM_WORDS];
    pixel_t     image [IMG_PIXELS];
    pixel_t     shadow [IMG_PIXELS];   // mirrors the frame buffer through the ram beats
    pixel_t     model [IMG_PIXELS];    // expected frame buffer contents
    addr_t      beat_addr [$];
    pixel_t     beat_data [$];
    int         n_cmds = 0;
    bit         ready = 1'b0;
    int         pos_x = POS_RESET;
    int         pos_y = POS_RESET;

    always #CLK_HALF clk = ~clk;

    assign rom_q = image[rom_addr];   // combinational rom

    lcd_ctrl u_dut (
        .clk       (clk),
        .reset     (reset),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .rom_q     (rom_q),
        .rom_rd    (rom_rd),
        .rom_addr  (rom_addr),
        .ram_valid (ram_valid),
        .ram_data  (ram_data),
        .ram_addr  (ram_addr),
        .busy      (busy),
        .done      (done)
    );

    always @(negedge clk) begin
        if (reset) begin
            for (int i = 0; i < IMG_PIXELS; i++) begin
                shadow[i[5:0]] = image[i[5:0]];
            end
        end else if (ram_valid) begin
            shadow[ram_addr] = ram_data;
            beat_addr.push_back(ram_addr);
            beat_data.push_back(ram_data);
        end
    end

    task automatic check_value(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("Error: time %0t, %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("RESULT: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic logic [7:0] word_at(input int idx);
        return stim[idx[8:0]];
    endfunction

    function automatic int count_commands(input int start);
        int         p;
        int         n;
        logic [7:0] w;
        p = start;
        n = 0;
        w = word_at(p);
        while (w != END_MARK) begin
            n++;
            p += (w[3:0] == CMD_WRITE) ? IMG_PIXELS + 1 : 1;   // skip the expected image
            w = word_at(p);
        end
        return n;
    endfunction

    function automatic void move_point(input cmd_t code);
        case (code)
            CMD_UP:    if (pos_y > POS_MIN) pos_y--;
            CMD_DOWN:  if (pos_y < POS_MAX) pos_y++;
            CMD_LEFT:  if (pos_x > POS_MIN) pos_x--;
            CMD_RIGHT: if (pos_x < POS_MAX) pos_x++;
            default:   ;
        endcase
    endfunction

    // k = 0..3 gives upper left, upper right, lower left, lower right
    function automatic int window_addr(input int k);
        return (pos_y - 1 + k / 2) * IMG_SIDE + pos_x - 1 + k % 2;
    endfunction

    function automatic int window_expect(input cmd_t code);
        int a;
        int v;
        int sum;
        int res;
        sum = 0;
        res = (code == CMD_MIN) ? 255 : 0;
        for (int k = 0; k < WIN_PIXELS; k++) begin
            a = window_addr(k);
            v = int'(model[a[5:0]]);
            sum += v;
            if (code == CMD_MAX && v > res) res = v;
            if (code == CMD_MIN && v < res) res = v;
        end
        return (code == CMD_AVG) ? sum / 4 : res;
    endfunction

    function automatic void update_model(input int value);
        int a;
        for (int k = 0; k < WIN_PIXELS; k++) begin
            a = window_addr(k);
            model[a[5:0]] = pixel_t'(value);
        end
    endfunction

    task automatic send_command(input cmd_t code, input bit with_spurious, input int n_spur);
        logic [7:0] w;
        @(posedge clk);
        cmd       <= code;
        cmd_valid <= 1'b1;
        @(posedge clk);
        cmd_valid <= 1'b0;
        @(negedge clk);
        check_value("busy", int'(busy), 1);
        if (with_spurious) begin
            for (int i = 0; i < n_spur; i++) begin
                w = word_at(SPUR_BASE + 1 + i);
                @(posedge clk);
                cmd       <= w[3:0];
                cmd_valid <= 1'b1;
                @(negedge clk);
                check_value("busy", int'(busy), 1);   // must be ignored
            end
            @(posedge clk);
            cmd_valid <= 1'b0;
        end
    endtask

    task automatic wait_idle();
        @(negedge clk);
        while (busy) begin
            @(negedge clk);
        end
    endtask

    task automatic check_write(input int start, input int base);
        check_value("write beats", beat_addr.size() - start, IMG_PIXELS);
        for (int i = 0; i < IMG_PIXELS; i++) begin
            check_value("ram_addr", int'(beat_addr[start + i]), i);
            check_value($sformatf("ram_data[%0d]", i), int'(shadow[i[5:0]]),
                        int'(word_at(base + i)));
        end
        check_value("done", int'(done), 1);
    endtask

    task automatic check_window(input int start, input int expected);
        check_value("window beats", beat_addr.size() - start, WIN_PIXELS);
        for (int k = 0; k < WIN_PIXELS; k++) begin
            check_value("ram_addr", int'(beat_addr[start + k]), window_addr(k));
            check_value("ram_data", int'(beat_data[start + k]), expected);
        end
    endtask

    initial begin
        int         ptr;
        int         n_spur;
        int         load_idx;
        int         start;
        int         expected;
        logic [7:0] w;
        cmd_t       code;
        bit         first_write;

        reset     = 1'b1;
        cmd       = 4'd0;
        cmd_valid = 1'b0;
        $readmemh("verif/lcd_input.txt", stim);
        for (int i = 0; i < IMG_PIXELS; i++) begin
            image[i[5:0]] = stim[i[8:0]];
            model[i[5:0]] = stim[i[8:0]];
        end
        n_spur = int'(word_at(SPUR_BASE));
        ptr    = SPUR_BASE + 1 + n_spur;
        n_cmds = count_commands(ptr);
        ready  = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        // image load from the rom
        load_idx = 0;
        @(negedge clk);
        check_value("ram_valid", int'(ram_valid), 0);
        check_value("done", int'(done), 0);
        while (rom_rd) begin
            check_value("rom_addr", int'(rom_addr), load_idx);
            check_value("busy", int'(busy), 1);
            load_idx++;
            @(negedge clk);
        end
        check_value("load beats", load_idx, IMG_PIXELS);
        check_value("busy", int'(busy), 1);
        @(negedge clk);
        check_value("busy", int'(busy), 0);

        first_write = 1'b1;
        while (word_at(ptr) != END_MARK) begin
            w     = word_at(ptr);
            code  = cmd_t'(w[3:0]);
            ptr++;
            start    = beat_addr.size();
            expected = window_expect(code);   // window result from the model
            send_command(code, first_write && code == CMD_WRITE, n_spur);
            wait_idle();
            case (code)
                CMD_WRITE: begin
                    check_write(start, ptr);
                    ptr += IMG_PIXELS;
                    first_write = 1'b0;
                end
                CMD_MAX, CMD_MIN, CMD_AVG: begin
                    check_window(start, expected);
                    update_model(expected);
                end
                default: begin
                    move_point(code);   // unused codes leave the point alone
                    check_value("ram beats", beat_addr.size() - start, 0);
                end
            endcase
        end

        $display("RESULT: PASS");
        $finish;
    end

    initial begin
        wait (ready);
        repeat ((n_cmds + 1) * CYCLES_PER_CMD) @(posedge clk);
        $display("Timeout: the DUT did not finish the command list in time");
        $display("RESULT: FAIL");
        $fatal(1, "stopped by the watchdog");
    end

endmodule

`default_nettype wire

/* verif/lcd_input.txt */
// words are 8-bit hex: 64 image pixels (16 per line, row-major), then spurious commands
// as a count and codes, then commands where 00 (write) is followed by its 64 expected pixels
3c 17 a5 42 08 d1 6e 90 5b 81 2f c7 14 e3 79 06
b2 4d 93 1e f0 65 2a cc 0f 58 e7 31 9a 7c 46 bd
d4 23 8e c9 5f 12 a8 67 71 f6 0b 84 3d ae 59 e2
9c 2e 65 d8 47 b0 13 fa e5 0a c3 7f 26 91 5d 38
// spurious, driven during the first write
04 05 01 07 00
// command list, ff ends it
00
3c 17 a5 42 08 d1 6e 90 5b 81 2f c7 14 e3 79 06
b2 4d 93 1e f0 65 2a cc 0f 58 e7 31 9a 7c 46 bd
d4 23 8e c9 5f 12 a8 67 71 f6 0b 84 3d ae 59 e2
9c 2e 65 d8 47 b0 13 fa e5 0a c3 7f 26 91 5d 38
05
00
3c 17 a5 42 08 d1 6e 90 5b 81 2f c7 14 e3 79 06
b2 4d 93 1e f0 65 2a cc 0f 58 e7 c9 c9 7c 46 bd
d4 23 8e c9 c9 12 a8 67 71 f6 0b 84 3d ae 59 e2
9c 2e 65 d8 47 b0 13 fa e5 0a c3 7f 26 91 5d 38
01 01 01 01 01 03 03 03 03 03 06 09
02 02 02 02 02 02 02 02 04 04 04 04 04 04 04 04 07
00
17 17 a5 42 08 d1 6e 90 17 17 2f c7 14 e3 79 06
b2 4d 93 1e f0 65 2a cc 0f 58 e7 c9 c9 7c 46 bd
d4 23 8e c9 c9 12 a8 67 71 f6 0b 84 3d ae 59 e2
9c 2e 65 d8 47 b0 68 68 e5 0a c3 7f 26 91 68 68
ff
